// ==== filelist.f ====
+incdir+bench
design/swt16_pkg.sv
design/fetch.sv
design/decoder.sv
design/regfile.sv
design/exec.sv
design/mem.sv
design/swt16.sv
bench/swt16_tb.sv

// ==== bench/swt16_model.svh ====
`ifndef SWT16_MODEL_SVH
`define SWT16_MODEL_SVH

localparam int PROG_LEN = 200;

word_t    prog [PROG_LEN];
wb_t      exp_wb [$];
dmem_wr_t exp_st [$];

// Mostly small values so data addresses collide and loads hit earlier stores
function automatic logic [7:0] pick_imm();
   if ($urandom_range(0, 3) != 0)
      return 8'($urandom_range(0, 15));
   else
      return 8'($urandom_range(0, 255));
endfunction

// Runs the ISA while it writes the program, one executed slot at a time
task automatic build_program();
   word_t      regs [16];
   word_t      dmem [256];
   int         slot;
   int         code;
   int         offset;
   logic [3:0] op;
   reg_idx_t   rd;
   reg_idx_t   ra;
   reg_idx_t   rb;
   logic [7:0] imm;
   word_t      value;
   logic       writes;
   wb_t        w;
   dmem_wr_t   s;
   foreach (regs[k])
      regs[k] = '0;
   foreach (dmem[k])
      dmem[k] = '0;
   slot = 0;
   while (slot < PROG_LEN) begin
      code = $urandom_range(0, 10);
      // Codes 10 to 15 behave as NOP
      if (code == 10)
         code = $urandom_range(10, 15);
      op     = code[3:0];
      rd     = reg_idx_t'($urandom_range(0, 7));
      ra     = reg_idx_t'($urandom_range(0, 7));
      rb     = reg_idx_t'($urandom_range(0, 7));
      imm    = pick_imm();
      offset = 1;
      writes = 1'b1;
      value  = '0;
      prog[slot] = {op, rd, ra, rb};
      case (op)
         ADD: value = regs[ra] + regs[rb];
         SUB: value = regs[ra] - regs[rb];
         AND: value = regs[ra] & regs[rb];
         OR:  value = regs[ra] | regs[rb];
         XOR: value = regs[ra] ^ regs[rb];
         LDI: begin
            prog[slot][7:0] = imm;
            value = {{8{imm[7]}}, imm};
         end
         LD:  value = dmem[regs[ra][7:0]];
         ST: begin
            writes = 1'b0;
            s.en   = 1'b1;
            s.addr = regs[ra];
            s.data = regs[rb];
            exp_st.push_back(s);
            dmem[regs[ra][7:0]] = regs[rb];
         end
         BZ: begin
            writes = 1'b0;
            prog[slot][7:0] = 8'($urandom_range(1, 6));
            if (regs[rd] == '0)
               offset = prog[slot][7:0];
         end
         default: writes = 1'b0;
      endcase
      if (writes && rd != '0) begin
         regs[rd] = value;
         w.en   = 1'b1;
         w.idx  = rd;
         w.data = value;
         exp_wb.push_back(w);
      end
      // Skipped slots get junk that must never retire
      for (int k = slot + 1; k < slot + offset && k < PROG_LEN; k++)
         prog[k] = word_t'($urandom());
      slot = slot + offset;
   end
endtask

`endif

// ==== bench/swt16_tb.sv ====
`timescale 1ns/100ps

module swt16_tb;
   import swt16_pkg::*;

   localparam int PC_WIDTH        = 12;
   localparam int PC_INCREMENT    = 2;
   localparam int DMEM_ADDR_WIDTH = 8;
   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 8;
   localparam int RUN_TIMEOUT     = 20000;
   localparam int DRAIN_CYCLES    = 20;

   logic                clock;
   logic                arst_n;
   logic [PC_WIDTH-1:0] pmem_addr;
   word_t               pmem_word;
   wb_t                 wb;
   dmem_wr_t            dmem_wr;

   // Address seen one cycle back, served now
   logic [PC_WIDTH-1:0] prev_addr;

   int wb_errors;
   int store_errors;
   int other_errors;
   int wb_seen;
   int store_seen;
   int wb_total;
   int store_total;

   `include "swt16_model.svh"

   swt16 #(
      .PC_WIDTH        (PC_WIDTH),
      .PC_INCREMENT    (PC_INCREMENT),
      .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
   ) uut (
      .clock     (clock),
      .arst_n    (arst_n),
      .pmem_addr (pmem_addr),
      .pmem_word (pmem_word),
      .wb        (wb),
      .dmem_wr   (dmem_wr)
   );

   initial begin
      clock = 1'b0;
      forever #(CLK_PERIOD / 2) clock = ~clock;
   end

   // Outside the program everything reads as NOP
   function automatic word_t word_at(logic [PC_WIDTH-1:0] addr);
      int idx;
      idx = int'(addr) / PC_INCREMENT;
      if (int'(addr) % PC_INCREMENT != 0 || idx >= PROG_LEN)
         return '0;
      else
         return prog[idx];
   endfunction

   task automatic check_wb(wb_t got);
      wb_t exp;
      wb_seen++;
      if (exp_wb.size() == 0) begin
         $display("unexpected writeback to register %0d with data %h", got.idx, got.data);
         wb_errors++;
      end else begin
         exp = exp_wb.pop_front();
         if (got.idx !== exp.idx) begin
            $display("FAILED wb.idx got %h expected %h", got.idx, exp.idx);
            wb_errors++;
         end
         if (got.data !== exp.data) begin
            $display("FAILED wb.data got %h expected %h", got.data, exp.data);
            wb_errors++;
         end
      end
   endtask

   task automatic check_store(dmem_wr_t got);
      dmem_wr_t exp;
      store_seen++;
      if (exp_st.size() == 0) begin
         $display("unexpected store of %h to address %h", got.data, got.addr);
         store_errors++;
      end else begin
         exp = exp_st.pop_front();
         if (got.addr !== exp.addr) begin
            $display("FAILED dmem_wr.addr got %h expected %h", got.addr, exp.addr);
            store_errors++;
         end
         if (got.data !== exp.data) begin
            $display("FAILED dmem_wr.data got %h expected %h", got.data, exp.data);
            store_errors++;
         end
      end
   endtask

   // Program memory server and mid-cycle output checks
   always @(negedge clock) begin
      pmem_word = word_at(prev_addr);
      prev_addr = pmem_addr;
      if (arst_n) begin
         if (wb.en)
            check_wb(wb);
         if (dmem_wr.en)
            check_store(dmem_wr);
      end
   end

   initial begin
      int cycles;
      void'($urandom(32'h4b98));
      arst_n       = 1'b0;
      pmem_word    = '0;
      prev_addr    = '0;
      wb_errors    = 0;
      store_errors = 0;
      other_errors = 0;
      wb_seen      = 0;
      store_seen   = 0;
      build_program();
      wb_total    = exp_wb.size();
      store_total = exp_st.size();
      repeat (RESET_CYCLES) @(negedge clock);
      arst_n = 1'b1;
      cycles = 0;
      while ((exp_wb.size() != 0 || exp_st.size() != 0) && cycles < RUN_TIMEOUT) begin
         @(negedge clock);
         cycles++;
      end
      if (exp_wb.size() != 0 || exp_st.size() != 0) begin
         $display("timeout after %0d cycles with %0d writebacks and %0d stores missing",
                  cycles, exp_wb.size(), exp_st.size());
         other_errors++;
      end
      // Late extras would still be caught here
      repeat (DRAIN_CYCLES) @(negedge clock);
      $display("errors wb %0d store %0d other %0d (wb %0d of %0d, stores %0d of %0d)",
               wb_errors, store_errors, other_errors,
               wb_seen, wb_total, store_seen, store_total);
      if (wb_errors + store_errors + other_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== design/swt16.sv ====
`timescale 1ns/100ps

module swt16 #(
   parameter int PC_WIDTH        = 12,
   parameter int PC_INCREMENT    = 2,
   parameter int DMEM_ADDR_WIDTH = 8
) (
   input  logic                 clock,
   input  logic                 arst_n,
   output logic [PC_WIDTH-1:0]  pmem_addr,
   input  swt16_pkg::word_t     pmem_word,
   output swt16_pkg::wb_t       wb,
   output swt16_pkg::dmem_wr_t  dmem_wr
);
   import swt16_pkg::*;

   if_dc_t  if_dc;
   dc_ex_t  dc_ex;
   ex_mem_t ex_mem;
   logic    stall;
   logic    branch_taken;
   word_t   branch_pc;

   // Fetch with program counter
   fetch #(.PC_WIDTH(PC_WIDTH), .PC_INCREMENT(PC_INCREMENT)) fetch_inst (
      .clock        (clock),
      .arst_n       (arst_n),
      .pmem_word    (pmem_word),
      .stall        (stall),
      .branch_taken (branch_taken),
      .branch_pc    (branch_pc),
      .pmem_addr    (pmem_addr),
      .if_dc        (if_dc)
   );

   // Decode, register file and bypass
   decoder decoder_inst (
      .clock  (clock),
      .arst_n (arst_n),
      .if_dc  (if_dc),
      .flush  (branch_taken),
      .ex_fwd (ex_mem),
      .wb     (wb),
      .dc_ex  (dc_ex),
      .stall  (stall)
   );

   exec #(.PC_INCREMENT(PC_INCREMENT)) exec_inst (
      .clock        (clock),
      .arst_n       (arst_n),
      .dc_ex        (dc_ex),
      .ex_mem       (ex_mem),
      .branch_taken (branch_taken),
      .branch_pc    (branch_pc)
   );

   mem #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) mem_inst (
      .clock   (clock),
      .arst_n  (arst_n),
      .ex_mem  (ex_mem),
      .wb      (wb),
      .dmem_wr (dmem_wr)
   );

endmodule

// ==== design/mem.sv ====
`timescale 1ns/100ps

module mem #(
   parameter int DMEM_ADDR_WIDTH = 8
) (
   input  logic                 clock,
   input  logic                 arst_n,
   input  swt16_pkg::ex_mem_t   ex_mem,
   output swt16_pkg::wb_t       wb,
   output swt16_pkg::dmem_wr_t  dmem_wr
);
   import swt16_pkg::*;

   localparam int DMEM_WORDS = 2**DMEM_ADDR_WIDTH;

   word_t                      dmem [DMEM_WORDS];
   logic [DMEM_ADDR_WIDTH-1:0] addr;
   logic                       store_en;
   word_t                      load_data;

   // Word addressed, upper address bits ignored
   assign addr      = ex_mem.result[DMEM_ADDR_WIDTH-1:0];
   assign store_en  = ex_mem.valid && ex_mem.opcode == ST;
   assign load_data = dmem[addr];

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] <= '0;
      end else if (store_en) begin
         dmem[addr] <= ex_mem.store_data;
      end
   end

   // MEM/WB register, drives the register file directly
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wb      <= '0;
         dmem_wr <= '0;
      end else begin
         wb.en        <= ex_mem.valid && writes_reg(ex_mem.opcode) && ex_mem.rd != '0;
         wb.idx       <= ex_mem.rd;
         wb.data      <= (ex_mem.opcode == LD) ? load_data : ex_mem.result;
         // Store report, one cycle after the array write
         dmem_wr.en   <= store_en;
         dmem_wr.addr <= ex_mem.result;
         dmem_wr.data <= ex_mem.store_data;
      end
   end

endmodule

// ==== design/exec.sv ====
`timescale 1ns/100ps

module exec #(
   parameter int PC_INCREMENT = 2
) (
   input  logic                clock,
   input  logic                arst_n,
   input  swt16_pkg::dc_ex_t   dc_ex,
   output swt16_pkg::ex_mem_t  ex_mem,
   output logic                branch_taken,
   output swt16_pkg::word_t    branch_pc
);
   import swt16_pkg::*;

   word_t result;
   word_t offset;

   always_comb begin
      case (dc_ex.opcode)
         ADD:     result = dc_ex.a + dc_ex.b;
         SUB:     result = dc_ex.a - dc_ex.b;
         AND:     result = dc_ex.a & dc_ex.b;
         OR:      result = dc_ex.a | dc_ex.b;
         XOR:     result = dc_ex.a ^ dc_ex.b;
         LDI:     result = dc_ex.imm;
         // Data address for the memory stage
         LD, ST:  result = dc_ex.a;
         default: result = '0;
      endcase
   end

   // Offset counts instructions, scale to pc units
   assign offset    = dc_ex.imm * word_t'(PC_INCREMENT);
   assign branch_pc = dc_ex.pc + offset;

   // Doubles as the flush of fetch and decode
   assign branch_taken = dc_ex.valid && dc_ex.opcode == BZ && dc_ex.a == '0;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem.valid      <= dc_ex.valid;
         ex_mem.opcode     <= dc_ex.opcode;
         ex_mem.rd         <= dc_ex.rd;
         ex_mem.result     <= result;
         ex_mem.store_data <= dc_ex.b;
      end
   end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
   input  logic                 clock,
   input  logic                 arst_n,
   input  swt16_pkg::wb_t       wb,
   input  swt16_pkg::reg_idx_t  rd_idx_a,
   input  swt16_pkg::reg_idx_t  rd_idx_b,
   output swt16_pkg::word_t     rd_a,
   output swt16_pkg::word_t     rd_b
);
   import swt16_pkg::*;

   word_t regs [2**REG_IDX_WIDTH];

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**REG_IDX_WIDTH; i++)
            regs[i] <= '0;
      end else if (wb.en && wb.idx != '0) begin
         regs[wb.idx] <= wb.data;
      end
   end

   // r0 is hardwired, a same-cycle write passes straight through
   assign rd_a = (rd_idx_a == '0) ? '0 :
                 (wb.en && wb.idx == rd_idx_a) ? wb.data : regs[rd_idx_a];
   assign rd_b = (rd_idx_b == '0) ? '0 :
                 (wb.en && wb.idx == rd_idx_b) ? wb.data : regs[rd_idx_b];

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/100ps

module decoder (
   input  logic                clock,
   input  logic                arst_n,
   input  swt16_pkg::if_dc_t   if_dc,
   input  logic                flush,
   input  swt16_pkg::ex_mem_t  ex_fwd,
   input  swt16_pkg::wb_t      wb,
   output swt16_pkg::dc_ex_t   dc_ex,
   output logic                stall
);
   import swt16_pkg::*;

   opcode_t  op;
   reg_idx_t idx_a;
   reg_idx_t idx_b;
   logic     use_a;
   logic     use_b;
   word_t    rf_a;
   word_t    rf_b;

   // Decode register, operands are patched on the way out
   dc_ex_t   dc_q;
   reg_idx_t idx_a_q;
   reg_idx_t idx_b_q;
   logic     use_a_q;
   logic     use_b_q;

   // Younger result first, loads are not ready in the EX/MEM register
   function automatic word_t forward(reg_idx_t idx, word_t raw, ex_mem_t ex, wb_t w);
      word_t value;
      value = raw;
      if (idx != '0) begin
         if (ex.valid && ex.opcode != LD && writes_reg(ex.opcode) && ex.rd == idx)
            value = ex.result;
         else if (w.en && w.idx == idx)
            value = w.data;
      end
      return value;
   endfunction

   always_comb begin
      if (if_dc.instr[15:12] > BZ)
         op = NOP;
      else
         op = opcode_t'(if_dc.instr[15:12]);
      // BZ tests the register in the rd field
      idx_a = (op == BZ) ? if_dc.instr[11:8] : if_dc.instr[7:4];
      idx_b = if_dc.instr[3:0];
      case (op)
         ADD, SUB, AND, OR, XOR, ST: begin
            use_a = 1'b1;
            use_b = 1'b1;
         end
         LD, BZ: begin
            use_a = 1'b1;
            use_b = 1'b0;
         end
         default: begin
            use_a = 1'b0;
            use_b = 1'b0;
         end
      endcase
   end

   regfile regfile_inst (
      .clock    (clock),
      .arst_n   (arst_n),
      .wb       (wb),
      .rd_idx_a (idx_a),
      .rd_idx_b (idx_b),
      .rd_a     (rf_a),
      .rd_b     (rf_b)
   );

   // Load still in MEM, its data shows up on wb one cycle later
   assign stall = dc_q.valid && ex_fwd.valid && ex_fwd.opcode == LD && ex_fwd.rd != '0 &&
                  ((use_a_q && idx_a_q == ex_fwd.rd) || (use_b_q && idx_b_q == ex_fwd.rd));

   always_comb begin
      dc_ex       = dc_q;
      dc_ex.a     = forward(idx_a_q, dc_q.a, ex_fwd, wb);
      dc_ex.b     = forward(idx_b_q, dc_q.b, ex_fwd, wb);
      dc_ex.valid = dc_q.valid && !stall;
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         dc_q    <= '0;
         idx_a_q <= '0;
         idx_b_q <= '0;
         use_a_q <= 1'b0;
         use_b_q <= 1'b0;
      end else if (flush) begin
         dc_q.valid <= 1'b0;
      end else if (stall) begin
         // Keep what wb forwards now, it is gone next cycle
         dc_q.a <= dc_ex.a;
         dc_q.b <= dc_ex.b;
      end else begin
         dc_q.valid  <= if_dc.valid;
         dc_q.opcode <= op;
         dc_q.rd     <= if_dc.instr[11:8];
         dc_q.a      <= rf_a;
         dc_q.b      <= rf_b;
         dc_q.imm    <= {{(WORD_WIDTH-8){if_dc.instr[7]}}, if_dc.instr[7:0]};
         dc_q.pc     <= if_dc.pc;
         idx_a_q     <= idx_a;
         idx_b_q     <= idx_b;
         use_a_q     <= use_a;
         use_b_q     <= use_b;
      end
   end

endmodule

// ==== design/fetch.sv ====
`timescale 1ns/100ps

module fetch #(
   parameter int PC_WIDTH     = 12,
   parameter int PC_INCREMENT = 2
) (
   input  logic                clock,
   input  logic                arst_n,
   input  swt16_pkg::word_t    pmem_word,
   input  logic                stall,
   input  logic                branch_taken,
   input  swt16_pkg::word_t    branch_pc,
   output logic [PC_WIDTH-1:0] pmem_addr,
   output swt16_pkg::if_dc_t   if_dc
);
   import swt16_pkg::*;

   word_t pc_q;
   word_t fetch_pc_q;
   logic  fetch_valid_q;
   // Copy of the stalled word, the pmem has already moved past it
   logic  hold_q;
   word_t hold_instr_q;

   assign pmem_addr = pc_q[PC_WIDTH-1:0];

   always_comb begin
      if_dc.instr = hold_q ? hold_instr_q : pmem_word;
      if_dc.pc    = fetch_pc_q;
      if_dc.valid = fetch_valid_q;
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         pc_q          <= '0;
         fetch_pc_q    <= '0;
         fetch_valid_q <= 1'b0;
         hold_q        <= 1'b0;
         hold_instr_q  <= '0;
      end else if (branch_taken) begin
         // Word arriving next cycle was fetched on the wrong path
         pc_q          <= branch_pc;
         fetch_valid_q <= 1'b0;
         hold_q        <= 1'b0;
      end else if (stall) begin
         hold_q        <= 1'b1;
         hold_instr_q  <= if_dc.instr;
      end else begin
         pc_q          <= pc_q + word_t'(PC_INCREMENT);
         fetch_pc_q    <= pc_q;
         fetch_valid_q <= 1'b1;
         hold_q        <= 1'b0;
      end
   end

endmodule

// ==== design/swt16_pkg.sv ====
package swt16_pkg;

   localparam int WORD_WIDTH    = 16;
   localparam int REG_IDX_WIDTH = 4;

   typedef logic [WORD_WIDTH-1:0]    word_t;
   typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

   // Instruction bits 15:12, codes 10 to 15 decode as NOP
   typedef enum logic [3:0] {
      NOP = 4'd0,
      ADD = 4'd1,
      SUB = 4'd2,
      AND = 4'd3,
      OR  = 4'd4,
      XOR = 4'd5,
      LDI = 4'd6,
      LD  = 4'd7,
      ST  = 4'd8,
      BZ  = 4'd9
   } opcode_t;

   // Pc fields are full words, only the low PC_WIDTH bits are meaningful
   typedef struct packed {
      logic    valid;
      word_t   instr;
      word_t   pc;
   } if_dc_t;

   typedef struct packed {
      logic     valid;
      opcode_t  opcode;
      reg_idx_t rd;
      word_t    a;
      word_t    b;
      word_t    imm;
      word_t    pc;
   } dc_ex_t;

   typedef struct packed {
      logic     valid;
      opcode_t  opcode;
      reg_idx_t rd;
      word_t    result;
      word_t    store_data;
   } ex_mem_t;

   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      word_t    data;
   } wb_t;

   typedef struct packed {
      logic  en;
      word_t addr;
      word_t data;
   } dmem_wr_t;

   // Opcodes that produce a register result
   function automatic logic writes_reg(opcode_t op);
      return op inside {ADD, SUB, AND, OR, XOR, LDI, LD};
   endfunction

endpackage
